// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;   // instruction or pc
    typedef logic [3:0]  ptr_t;    // fifo pointer, wraps at depth
    typedef logic [3:0]  count_t;  // fifo occupancy

    localparam int     FIFO_DEPTH = 16;
    localparam count_t FULL_LEVEL = 4'd14;  // two more words would not fit
    localparam word_t  RESET_PC   = 32'hbfc00000;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;

    // SPECIAL function field, inst[5:0]
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_JALR    = 6'h09;

    typedef enum logic [1:0] {
        FETCH_IDLE,  // free to request
        FETCH_WAIT,  // one request outstanding
        FETCH_DROP   // outstanding response is stale
    } fetch_state_t;

endpackage

`default_nettype wire

// File: fetch_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// two-slot write from the fetch unit into the instruction fifo
interface fetch_wr_if import fetch_pkg::*; ();

    logic  write_en1;    // slot 1 strobe
    logic  write_en2;    // slot 2, only together with slot 1
    word_t write_pc1;
    word_t write_pc2;
    word_t write_inst1;
    word_t write_inst2;

    modport fetch (
        output write_en1, write_en2,
        output write_pc1, write_pc2,
        output write_inst1, write_inst2
    );

    modport fifo (
        input write_en1, write_en2,
        input write_pc1, write_pc2,
        input write_inst1, write_inst2
    );

endinterface

`default_nettype wire

// File: inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch import fetch_pkg::*; (
    input  wire logic  clk,
    input  wire logic  fifo_rst,
    input  wire logic  full,
    input  wire logic  redirect_valid,
    input  wire word_t redirect_pc,
    input  wire logic  inst_ok,
    input  wire logic  inst_ok_2,
    input  wire word_t inst_rdata1,
    input  wire word_t inst_rdata2,
    output logic       flush,
    output logic       inst_req,
    output word_t      inst_addr,
    fetch_wr_if.fetch  wr
);

    fetch_state_t state;
    word_t        pc;
    logic         resp_take;  // response written this cycle

    assign flush     = redirect_valid;
    assign inst_addr = pc;  // pc is steady while a request is outstanding

    // a response racing a redirect is thrown away
    assign resp_take = (state == FETCH_WAIT) && inst_ok && !redirect_valid;

    assign wr.write_en1   = resp_take;
    assign wr.write_en2   = resp_take && inst_ok_2;
    assign wr.write_pc1   = pc;
    assign wr.write_pc2   = pc + 32'd4;
    assign wr.write_inst1 = inst_rdata1;
    assign wr.write_inst2 = inst_rdata2;

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            state    <= FETCH_IDLE;
            inst_req <= 1'b0;
            pc       <= RESET_PC;
        end else begin
            inst_req <= 1'b0;  // single-cycle strobe

            if (redirect_valid)
                pc <= redirect_pc;
            else if (resp_take)
                pc <= pc + (inst_ok_2 ? 32'd8 : 32'd4);

            case (state)
                FETCH_IDLE: begin
                    if (!full && !redirect_valid) begin
                        inst_req <= 1'b1;
                        state    <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (inst_ok)
                        state <= FETCH_IDLE;  // consumed, written or dropped
                    else if (redirect_valid)
                        state <= FETCH_DROP;
                end
                FETCH_DROP: begin
                    if (inst_ok)
                        state <= FETCH_IDLE;  // stale words discarded
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo import fetch_pkg::*; (
    input  wire logic clk,
    input  wire logic fifo_rst,
    input  wire logic flush,
    fetch_wr_if.fifo  wr,
    input  wire logic read_en1,
    input  wire logic read_en2,
    input  wire logic master_is_branch,
    output logic      head_valid1,
    output logic      head_valid2,
    output word_t     head_inst1,
    output word_t     head_inst2,
    output word_t     head_pc1,
    output word_t     head_pc2,
    output logic      in_delayslot,
    output logic      full
);

    word_t  inst_mem [FIFO_DEPTH];
    word_t  pc_mem   [FIFO_DEPTH];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    logic   empty;
    logic   almost_empty;  // exactly one entry
    logic   rd1;
    logic   rd2;

    assign full         = (count >= FULL_LEVEL);
    assign empty        = (count == 4'd0);
    assign almost_empty = (count == 4'd1);

    // reads that actually remove entries
    assign rd1 = read_en1 && !empty;
    assign rd2 = rd1 && read_en2 && !almost_empty;

    // storage, slot 2 lands right behind slot 1
    always_ff @(posedge clk) begin
        if (wr.write_en1) begin
            inst_mem[wr_ptr] <= wr.write_inst1;
            pc_mem[wr_ptr]   <= wr.write_pc1;
        end
        if (wr.write_en2) begin
            inst_mem[wr_ptr + 4'd1] <= wr.write_inst2;
            pc_mem[wr_ptr + 4'd1]   <= wr.write_pc2;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst || flush)
            wr_ptr <= '0;
        else if (wr.write_en1 && wr.write_en2)
            wr_ptr <= wr_ptr + 4'd2;
        else if (wr.write_en1)
            wr_ptr <= wr_ptr + 4'd1;
    end

    always_ff @(posedge clk) begin
        if (fifo_rst || flush)
            rd_ptr <= '0;
        else if (rd2)
            rd_ptr <= rd_ptr + 4'd2;
        else if (rd1)
            rd_ptr <= rd_ptr + 4'd1;
    end

    // writes counted first, slot 1 before slot 2
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            count <= '0;
        end else begin
            case ({wr.write_en1, wr.write_en2, rd1, rd2})
                4'b1100:          count <= count + 4'd2;
                4'b1110, 4'b1000: count <= count + 4'd1;
                4'b1011, 4'b0010: count <= count - 4'd1;
                4'b0011:          count <= count - 4'd2;
                default:          count <= count;  // 1111, 1010, idle
            endcase
        end
    end

    // head pair follows count one edge later
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            head_valid1 <= 1'b0;
            head_valid2 <= 1'b0;
        end else begin
            head_valid1 <= !empty;
            head_valid2 <= !empty && !almost_empty;
        end
    end

    always_ff @(posedge clk) begin
        head_inst1 <= inst_mem[rd_ptr];
        head_inst2 <= inst_mem[rd_ptr + 4'd1];
        head_pc1   <= pc_mem[rd_ptr];
        head_pc2   <= pc_mem[rd_ptr + 4'd1];
    end

    // a branch leaving alone puts the next master in its delay slot
    // held between reads so it lines up with the refreshed head
    always_ff @(posedge clk) begin
        if (fifo_rst)
            in_delayslot <= 1'b0;
        else if (rd1)
            in_delayslot <= master_is_branch && !rd2;
    end

endmodule

`default_nettype wire

// File: issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select import fetch_pkg::*; (
    input  wire logic  clk,
    input  wire logic  fifo_rst,
    input  wire logic  issue_stall,
    input  wire logic  head_valid1,
    input  wire logic  head_valid2,
    input  wire word_t head_inst1,
    input  wire word_t head_inst2,
    input  wire word_t head_pc1,
    input  wire word_t head_pc2,
    output logic       read_en1,
    output logic       read_en2,
    output logic       master_is_branch,
    output logic       issue_valid1,
    output logic       issue_valid2,
    output word_t      issue_inst1,
    output word_t      issue_inst2,
    output word_t      issue_pc1,
    output word_t      issue_pc2
);

    logic       last_read;  // head not refreshed yet
    logic [4:0] m_dest;     // register written by the master
    logic       slave_dep;

    function automatic logic is_branch(word_t inst);
        logic [5:0] op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        case (op)
            OP_SPECIAL: is_branch = (fn == FN_JR) || (fn == FN_JALR);
            OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
                is_branch = 1'b1;
            default:    is_branch = 1'b0;
        endcase
    endfunction

    always_comb begin
        m_dest = 5'd0;
        case (head_inst1[31:26])
            OP_SPECIAL: m_dest = head_inst1[15:11];  // rd
            OP_JAL:     m_dest = 5'd31;              // link register
            default: begin
                // immediate alu and loads write rt
                if (head_inst1[31:29] == 3'b001 || head_inst1[31:29] == 3'b100)
                    m_dest = head_inst1[20:16];
            end
        endcase
    end

    assign slave_dep = (m_dest != 5'd0) &&
                       ((head_inst2[25:21] == m_dest) || (head_inst2[20:16] == m_dest));

    assign master_is_branch = is_branch(head_inst1);

    assign read_en1 = head_valid1 && !issue_stall && !last_read;
    assign read_en2 = read_en1 && head_valid2 && !is_branch(head_inst2) && !slave_dep;

    always_ff @(posedge clk) begin
        if (fifo_rst)
            last_read <= 1'b0;
        else
            last_read <= read_en1;
    end

    assign issue_valid1 = read_en1;
    assign issue_valid2 = read_en2;
    assign issue_inst1  = read_en1 ? head_inst1 : '0;
    assign issue_pc1    = read_en1 ? head_pc1   : '0;
    assign issue_inst2  = read_en2 ? head_inst2 : '0;
    assign issue_pc2    = read_en2 ? head_pc2   : '0;

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic  clk,
    input  wire logic  fifo_rst,
    input  wire logic  redirect_valid,
    input  wire word_t redirect_pc,
    input  wire logic  inst_ok,
    input  wire logic  inst_ok_2,
    input  wire word_t inst_rdata1,
    input  wire word_t inst_rdata2,
    input  wire logic  issue_stall,
    output logic       inst_req,
    output word_t      inst_addr,
    output logic       issue_valid1,
    output logic       issue_valid2,
    output word_t      issue_inst1,
    output word_t      issue_inst2,
    output word_t      issue_pc1,
    output word_t      issue_pc2,
    output logic       issue_in_delayslot
);

    logic  flush;
    logic  full;
    logic  head_valid1;
    logic  head_valid2;
    word_t head_inst1;
    word_t head_inst2;
    word_t head_pc1;
    word_t head_pc2;
    logic  read_en1;
    logic  read_en2;
    logic  master_is_branch;

    fetch_wr_if wr_bus ();

    inst_fetch u_fetch (
        .clk            (clk),
        .fifo_rst       (fifo_rst),
        .full           (full),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_ok        (inst_ok),
        .inst_ok_2      (inst_ok_2),
        .inst_rdata1    (inst_rdata1),
        .inst_rdata2    (inst_rdata2),
        .flush          (flush),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .wr             (wr_bus.fetch)
    );

    inst_fifo u_fifo (
        .clk              (clk),
        .fifo_rst         (fifo_rst),
        .flush            (flush),
        .wr               (wr_bus.fifo),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .head_valid1      (head_valid1),
        .head_valid2      (head_valid2),
        .head_inst1       (head_inst1),
        .head_inst2       (head_inst2),
        .head_pc1         (head_pc1),
        .head_pc2         (head_pc2),
        .in_delayslot     (issue_in_delayslot),
        .full             (full)
    );

    issue_select u_select (
        .clk              (clk),
        .fifo_rst         (fifo_rst),
        .issue_stall      (issue_stall),
        .head_valid1      (head_valid1),
        .head_valid2      (head_valid2),
        .head_inst1       (head_inst1),
        .head_inst2       (head_inst2),
        .head_pc1         (head_pc1),
        .head_pc2         (head_pc2),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .issue_valid1     (issue_valid1),
        .issue_valid2     (issue_valid2),
        .issue_inst1      (issue_inst1),
        .issue_inst2      (issue_inst2),
        .issue_pc1        (issue_pc1),
        .issue_pc2        (issue_pc2)
    );

endmodule

`default_nettype wire

// File: fetch_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top_chk import fetch_pkg::*; (
    input wire logic         clk,
    input wire logic         fifo_rst,
    input wire logic         full,
    input wire logic         write_en1,
    input wire logic         inst_req,
    input wire fetch_state_t state,
    input wire logic         issue_valid1,
    input wire logic         issue_valid2,
    input wire word_t        issue_pc1,
    input wire word_t        issue_pc2
);

    int fail_count = 0;  // assertion failures so far

    // one outstanding request always fits
    a_no_write_full: assert property (@(posedge clk) disable iff (fifo_rst)
        !(write_en1 && full))
        else begin
            $error("fifo written while full");
            fail_count++;
        end

    a_req_from_idle: assert property (@(posedge clk) disable iff (fifo_rst)
        inst_req |-> $past(state) == FETCH_IDLE)
        else begin
            $error("request issued outside idle state");
            fail_count++;
        end

    // the slave is the word right behind its master
    a_slave_behind_master: assert property (@(posedge clk) disable iff (fifo_rst)
        issue_valid2 |-> issue_valid1 && (issue_pc2 == issue_pc1 + 32'd4))
        else begin
            $error("slave issued without the master right before it");
            fail_count++;
        end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(fifo_rst) |-> !inst_req && !issue_valid1 && !issue_valid2)
        else begin
            $error("outputs active right after reset");
            fail_count++;
        end

endmodule

bind fetch_top fetch_top_chk chk0 (
    .clk          (clk),
    .fifo_rst     (fifo_rst),
    .full         (full),
    .write_en1    (wr_bus.write_en1),
    .inst_req     (inst_req),
    .state        (u_fetch.state),
    .issue_valid1 (issue_valid1),
    .issue_valid2 (issue_valid2),
    .issue_pc1    (issue_pc1),
    .issue_pc2    (issue_pc2)
);

`default_nettype wire

// File: tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

    localparam int TOTAL_INSTR = 388;  // sum of words the tests wait for

    logic  clk;
    logic  fifo_rst;
    logic  redirect_valid;
    word_t redirect_pc;
    logic  inst_ok;
    logic  inst_ok_2;
    word_t inst_rdata1;
    word_t inst_rdata2;
    logic  issue_stall;
    logic  inst_req;
    word_t inst_addr;
    logic  issue_valid1;
    logic  issue_valid2;
    word_t issue_inst1;
    word_t issue_inst2;
    word_t issue_pc1;
    word_t issue_pc2;
    logic  issue_in_delayslot;

    word_t       prog [256];
    logic [31:0] lfsr = 32'd69823;
    word_t       req_addr;
    int          lat_left;
    word_t       exp_pc;
    logic        exp_ds;
    int          issued;
    int          bank;  // words known to sit in the fifo after a prefill
    word_t       fetch_pc;     // where the next request must point
    logic        req_pending;
    logic        resp_stale;   // redirect seen while waiting

    fetch_top dut0 (.*);

    always #50 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [3:0] take_bits(int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t prog_word(word_t pc);
        word_t off;
        off = pc - RESET_PC;
        return prog[off[9:2]];
    endfunction

    function automatic word_t r_type(logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, 6'h21};
    endfunction

    function automatic word_t i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt);
        return {op, rs, rt, 16'h0010};
    endfunction

    // control transfers from the opcode map
    function automatic logic is_jump(word_t w);
        if (w[31:26] == OP_SPECIAL)
            return w[5:0] == FN_JR || w[5:0] == FN_JALR;
        return w[31:26] inside {OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};
    endfunction

    function automatic logic depends(word_t m, word_t s);
        logic [4:0] d;
        d = 5'd0;
        if (m[31:26] == OP_SPECIAL)
            d = m[15:11];
        else if (m[31:26] == OP_JAL)
            d = 5'd31;
        else if (m[31:29] == 3'b001 || m[31:29] == 3'b100)
            d = m[20:16];  // immediate alu or load
        return d != 5'd0 && (s[25:21] == d || s[20:16] == d);
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            if (i < 128)
                prog[i] = r_type(5'd8 + 5'(i % 8), 5'd0, 5'd0);
            else
                case (i % 6)
                    0: prog[i] = r_type(5'((i % 7) + 1), 5'(i % 5), 5'd0);
                    1: prog[i] = i_type(6'h09, 5'((i % 3) + 1), 5'((i % 7) + 1));
                    2: prog[i] = i_type(OP_BEQ, 5'(i % 4), 5'd2);
                    3: prog[i] = i_type(6'h23, 5'(i % 6), 5'((i % 5) + 1));
                    4: prog[i] = r_type(5'(i % 4), 5'((i % 7) + 1), 5'(i % 3));
                    default: prog[i] = {OP_SPECIAL, 5'd31, 15'd0, FN_JR};
                endcase
        end
        prog[64] = r_type(5'd5, 5'd0, 5'd0);
        prog[65] = r_type(5'd6, 5'd5, 5'd0);   // reads master rd
        prog[67] = i_type(OP_BEQ, 5'd1, 5'd2); // branch paired with its slave
        prog[69] = i_type(6'h09, 5'd0, 5'd9);
        prog[70] = r_type(5'd3, 5'd0, 5'd9);   // reads master rt
        prog[96] = {OP_J, 26'h40};
        prog[97] = {OP_J, 26'h80};             // branch in delay slot
        prog[100] = i_type(OP_BEQ, 5'd1, 5'd2);
        prog[102] = {OP_JAL, 26'h44};
        prog[103] = r_type(5'd4, 5'd31, 5'd0);
    endtask

    // instruction memory serving one request at a time
    always @(negedge clk) begin
        inst_ok   = 1'b0;
        inst_ok_2 = 1'b0;
        if (fifo_rst) begin
            lat_left = 0;
        end else if (inst_req) begin
            lat_left = take_bits(2) + 1;
            req_addr = inst_addr;
        end else if (lat_left > 0) begin
            lat_left--;
            if (lat_left == 0) begin
                inst_ok     = 1'b1;
                inst_ok_2   = (take_bits(1) != 4'd0);
                inst_rdata1 = prog_word(req_addr);
                inst_rdata2 = prog_word(req_addr + 32'd4);
            end
        end
    end

    // reference model of the issue stream
    always @(posedge clk) begin
        logic pair_ok;
        int   n;
        if (!fifo_rst) begin
            if (issue_valid1) begin
                check_word("issue_pc1", issue_pc1, exp_pc);
                check_word("issue_inst1", issue_inst1, prog_word(exp_pc));
                check_bit("issue_in_delayslot", issue_in_delayslot, exp_ds);
                pair_ok = !is_jump(prog_word(exp_pc + 32'd4)) &&
                          !depends(prog_word(exp_pc), prog_word(exp_pc + 32'd4));
                if (bank >= 2)
                    check_bit("issue_valid2", issue_valid2, pair_ok);
                else if (issue_valid2)
                    check_bit("slave pairing allowed", pair_ok, 1'b1);
                if (issue_valid2) begin
                    check_word("issue_pc2", issue_pc2, exp_pc + 32'd4);
                    check_word("issue_inst2", issue_inst2, prog_word(exp_pc + 32'd4));
                end
                exp_ds = is_jump(prog_word(exp_pc)) && !issue_valid2;
                n = issue_valid2 ? 2 : 1;
                exp_pc = exp_pc + 32'(4 * n);
                issued = issued + n;
                bank = (bank > n) ? bank - n : 0;
            end
            // fetch address stream with stale answers dropped
            if (inst_req) begin
                check_word("inst_addr", inst_addr, fetch_pc);
                req_pending = 1'b1;
            end
            if (inst_ok) begin
                if (!resp_stale && !redirect_valid)
                    fetch_pc = fetch_pc + (inst_ok_2 ? 32'd8 : 32'd4);
                req_pending = 1'b0;
                resp_stale  = 1'b0;
            end else if (req_pending && redirect_valid) begin
                resp_stale = 1'b1;
            end
            if (redirect_valid) begin
                exp_pc   = redirect_pc;
                fetch_pc = redirect_pc;
                bank     = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (dut0.chk0.fail_count != 0) begin
            $display("assertion failure reported by the bound checker");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic wait_issued(int n);
        int target;
        target = issued + n;
        while (issued < target)
            @(negedge clk);
    endtask

    task automatic redirect_to(word_t pc);
        @(negedge clk);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    // stall, restart at pc, let the fifo fill up
    task automatic prefill(word_t pc);
        @(negedge clk);
        issue_stall = 1'b1;
        redirect_to(pc);
        repeat (120) @(negedge clk);
        bank = 14;
    endtask

    task automatic sequential_flow();
        wait_issued(24);
    endtask

    task automatic backpressure_fill();
        prefill(RESET_PC + 32'd128);
        repeat (30) begin
            @(posedge clk);
            check_bit("inst_req", inst_req, 1'b0);  // fifo full
        end
        @(negedge clk);
        issue_stall = 1'b0;
        wait_issued(16);
    endtask

    task automatic pairing_rules();
        prefill(RESET_PC + 32'd256);
        issue_stall = 1'b0;
        wait_issued(16);
    endtask

    task automatic delay_slot_flag();
        prefill(RESET_PC + 32'd384);
        issue_stall = 1'b0;
        wait_issued(16);
    endtask

    task automatic redirect_in_flight();
        @(posedge clk);
        while (!inst_req)
            @(posedge clk);
        redirect_to(RESET_PC + 32'd40);  // response still in flight
        wait_issued(16);
    endtask

    task automatic mixed_random_run();
        int   target;
        logic stall_next;
        redirect_to(RESET_PC + 32'd512);
        target = issued + 300;
        while (issued < target) begin
            @(posedge clk);
            stall_next = (take_bits(2) == 4'd3);
            @(negedge clk);
            issue_stall = stall_next;
        end
        issue_stall = 1'b0;
    endtask

    initial begin
        #(200.0 * TOTAL_INSTR * 100.0);
        $display("watchdog: the tests did not finish in time");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        clk            = 1'b0;
        fifo_rst       = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        inst_ok        = 1'b0;
        inst_ok_2      = 1'b0;
        inst_rdata1    = '0;
        inst_rdata2    = '0;
        issue_stall    = 1'b0;
        exp_pc         = RESET_PC;
        exp_ds         = 1'b0;
        issued         = 0;
        bank           = 0;
        fetch_pc       = RESET_PC;
        req_pending    = 1'b0;
        resp_stale     = 1'b0;
        build_program();
        repeat (8) @(negedge clk);
        fifo_rst = 1'b0;
        sequential_flow();
        backpressure_fill();
        pairing_rules();
        delay_slot_flag();
        redirect_in_flight();
        mixed_random_run();
        if (dut0.chk0.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("assertion failure reported by the bound checker");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: fetch_top.f
fetch_pkg.sv
fetch_wr_if.sv
inst_fetch.sv
inst_fifo.sv
issue_select.sv
fetch_top.sv
fetch_top_chk.sv
tb_fetch_top.sv
